//--- include/vexp_defines.svh
`ifndef VEXP_DEFINES_SVH
`define VEXP_DEFINES_SVH

////////////////////////////////////////////////////////////
// Fixed point format
////////////////////////////////////////////////////////////

// Full word width of a Q16.16 value
`define VEXP_DATA_W 32

// Bits below the binary point
`define VEXP_FRAC_W 16

////////////////////////////////////////////////////////////
// Series and vector sizing
////////////////////////////////////////////////////////////

// Taylor terms summed per element, including the leading 1.0
`define VEXP_TERMS 12

// Width of the vector length and the element index
`define VEXP_LEN_W 16

// Engine start to done, two states per term after the first plus done
`define VEXP_ENGINE_LAT (2 * (`VEXP_TERMS - 1) + 1)

`endif

//--- src/vexp_pkg.sv
`include "vexp_defines.svh"

package vexp_pkg;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  // Signed Q16.16 word for inputs, terms, sums and results
  typedef logic signed [`VEXP_DATA_W-1:0] fix_t;

  // Vector length and running element index
  typedef logic [`VEXP_LEN_W-1:0] len_t;

  // Index of the Taylor term being built
  typedef logic [$clog2(`VEXP_TERMS)-1:0] term_idx_t;

  ////////////////////////////////////////////////////////////
  // FSM encodings
  ////////////////////////////////////////////////////////////

  // Input side
  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } seq_state_t;

  // Series engine
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_MUL_X,
    ENG_MUL_INV,
    ENG_DONE
  } eng_state_t;

endpackage

//--- src/vexp_input_sequencer.sv
module vexp_input_sequencer (
  input  logic           CLK,
  input  logic           RST,

  // Vector control from the source
  input  logic           START,
  input  vexp_pkg::len_t SIZE_IN,
  input  logic           DATA_IN_ENABLE,
  input  vexp_pkg::fix_t DATA_IN,

  // Engine handoff
  input  logic           eng_busy,
  output logic           eng_start,
  output vexp_pkg::fix_t eng_x,
  output logic           eng_last
);

  import vexp_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Vector bookkeeping
  seq_state_t state_q;
  len_t       len_q;
  len_t       idx_q;

  // Strobe accepted this cycle
  logic       capture;
  // Current element is the final one of the vector
  logic       is_last;

  // One-deep holding slot
  logic       slot_full;
  fix_t       slot_x;
  logic       slot_last;

  ////////////////////////////////////////////////////////////
  // Element capture
  ////////////////////////////////////////////////////////////

  // Strobes outside an active vector are dropped
  assign capture = (state_q == SEQ_RUN) && DATA_IN_ENABLE;

  // Zero length is not supported so len_q - 1 never wraps in use
  assign is_last = (idx_q == len_t'(len_q - 1'b1));

  // Length latch and element counter
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= SEQ_IDLE;
      len_q   <= '0;
      idx_q   <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          // New vector, sample its length
          if (START) begin
            len_q   <= SIZE_IN;
            idx_q   <= '0;
            state_q <= SEQ_RUN;
          end
        end
        SEQ_RUN: begin
          if (capture) begin
            idx_q <= len_t'(idx_q + 1'b1);
            // Vector fully received
            if (is_last) begin
              state_q <= SEQ_IDLE;
            end
          end
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Holding slot
  ////////////////////////////////////////////////////////////

  // A capture in the handoff cycle refills the slot at once
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      slot_full <= 1'b0;
    end else if (capture) begin
      slot_full <= 1'b1;
    end else if (eng_start) begin
      slot_full <= 1'b0;
    end
  end

  // Element value and its last tag
  always_ff @(posedge CLK) begin
    if (capture) begin
      slot_x    <= DATA_IN;
      slot_last <= is_last;
    end
  end

  // Hand over as soon as the engine is free
  assign eng_start = slot_full && !eng_busy;
  assign eng_x     = slot_x;
  assign eng_last  = slot_last;

endmodule

//--- src/vexp_scalar_exponentiator.sv
`include "vexp_defines.svh"

module vexp_scalar_exponentiator (
  input  logic           CLK,
  input  logic           RST,

  // Element from the sequencer
  input  logic           eng_start,
  input  vexp_pkg::fix_t eng_x,
  input  logic           eng_last,

  // Status and result
  output logic           eng_busy,
  output logic           eng_done,
  output vexp_pkg::fix_t eng_result,
  output logic           eng_result_last
);

  import vexp_pkg::*;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  // 1.0 in Q16.16
  localparam fix_t ONE = fix_t'(1 << `VEXP_FRAC_W);

  // Index of the final term
  localparam term_idx_t LAST_IDX = term_idx_t'(`VEXP_TERMS - 1);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Control
  eng_state_t state_q;
  term_idx_t  idx_q;

  // Operand and series registers
  fix_t       x_q;
  logic       last_q;
  fix_t       term_q;
  fix_t       sum_q;
  fix_t       prod_q;

  // Full width products
  logic signed [2*`VEXP_DATA_W-1:0] mul_x_full;
  logic signed [2*`VEXP_DATA_W-1:0] mul_inv_full;

  // Rescaled products
  fix_t       x_prod;
  fix_t       new_term;

  // Table entry for the current index
  fix_t       recip;

  ////////////////////////////////////////////////////////////
  // Reciprocal table
  ////////////////////////////////////////////////////////////

  // floor(1.0 / k) in Q16.16 for k = 1 .. TERMS-1
  always_comb begin
    case (idx_q)
      1:       recip = ONE;
      2:       recip = fix_t'(ONE / 2);
      3:       recip = fix_t'(ONE / 3);
      4:       recip = fix_t'(ONE / 4);
      5:       recip = fix_t'(ONE / 5);
      6:       recip = fix_t'(ONE / 6);
      7:       recip = fix_t'(ONE / 7);
      8:       recip = fix_t'(ONE / 8);
      9:       recip = fix_t'(ONE / 9);
      10:      recip = fix_t'(ONE / 10);
      11:      recip = fix_t'(ONE / 11);
      // Index 0 is the seed term and never multiplied
      default: recip = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Multipliers
  ////////////////////////////////////////////////////////////

  // term * x, back to Q16.16
  assign mul_x_full = term_q * x_q;
  assign x_prod     = fix_t'(mul_x_full >>> `VEXP_FRAC_W);

  // (term * x) / k, back to Q16.16
  assign mul_inv_full = prod_q * recip;
  assign new_term     = fix_t'(mul_inv_full >>> `VEXP_FRAC_W);

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= ENG_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        ENG_IDLE: begin
          if (eng_start) begin
            // Term 0 is loaded directly, loop starts at term 1
            idx_q   <= term_idx_t'(1);
            state_q <= ENG_MUL_X;
          end
        end
        ENG_MUL_X: begin
          state_q <= ENG_MUL_INV;
        end
        ENG_MUL_INV: begin
          if (idx_q == LAST_IDX) begin
            state_q <= ENG_DONE;
          end else begin
            idx_q   <= term_idx_t'(idx_q + 1'b1);
            state_q <= ENG_MUL_X;
          end
        end
        ENG_DONE: begin
          state_q <= ENG_IDLE;
        end
        default: begin
          state_q <= ENG_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state_q)
      ENG_IDLE: begin
        // Seed series with 1.0
        if (eng_start) begin
          x_q    <= eng_x;
          last_q <= eng_last;
          term_q <= ONE;
          sum_q  <= ONE;
        end
      end
      ENG_MUL_X: begin
        prod_q <= x_prod;
      end
      ENG_MUL_INV: begin
        // Sum wraps at 32 bits
        term_q <= new_term;
        sum_q  <= sum_q + new_term;
      end
      default: ;
    endcase
  end

  // Busy through the done cycle
  assign eng_busy        = (state_q != ENG_IDLE);
  assign eng_done        = (state_q == ENG_DONE);
  assign eng_result      = sum_q;
  assign eng_result_last = last_q;

endmodule

//--- src/vexp_output_stage.sv
module vexp_output_stage (
  input  logic           CLK,
  input  logic           RST,

  // Result from the engine
  input  logic           eng_done,
  input  vexp_pkg::fix_t eng_result,
  input  logic           eng_result_last,

  // External outputs
  output vexp_pkg::fix_t DATA_OUT,
  output logic           DATA_OUT_ENABLE,
  output logic           READY
);

  ////////////////////////////////////////////////////////////
  // Output pulses
  ////////////////////////////////////////////////////////////

  // One pulse per result, one cycle after eng_done
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      DATA_OUT_ENABLE <= eng_done;
      // Vector complete with its tagged element
      READY           <= eng_done && eng_result_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////

  // Holds between pulses
  always_ff @(posedge CLK) begin
    if (eng_done) begin
      DATA_OUT <= eng_result;
    end
  end

endmodule

//--- src/vexp_top.sv
module vexp_top (
  input  logic           CLK,
  input  logic           RST,

  // Vector input side
  input  logic           START,
  input  vexp_pkg::len_t SIZE_IN,
  input  logic           DATA_IN_ENABLE,
  input  vexp_pkg::fix_t DATA_IN,

  // Result side
  output vexp_pkg::fix_t DATA_OUT,
  output logic           DATA_OUT_ENABLE,
  output logic           READY
);

  import vexp_pkg::*;

  ////////////////////////////////////////////////////////////
  // Inter-stage wires
  ////////////////////////////////////////////////////////////

  // Sequencer to engine
  logic eng_start;
  fix_t eng_x;
  logic eng_last;

  // Engine back to sequencer
  logic eng_busy;

  // Engine to output stage
  logic eng_done;
  fix_t eng_result;
  logic eng_result_last;

  ////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////

  // Length sampling, holding slot and engine start
  vexp_input_sequencer vexp_input_sequencer_inst (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .SIZE_IN        (SIZE_IN),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_IN        (DATA_IN),
    .eng_busy       (eng_busy),
    .eng_start      (eng_start),
    .eng_x          (eng_x),
    .eng_last       (eng_last)
  );

  // Taylor series engine
  vexp_scalar_exponentiator vexp_scalar_exponentiator_inst (
    .CLK             (CLK),
    .RST             (RST),
    .eng_start       (eng_start),
    .eng_x           (eng_x),
    .eng_last        (eng_last),
    .eng_busy        (eng_busy),
    .eng_done        (eng_done),
    .eng_result      (eng_result),
    .eng_result_last (eng_result_last)
  );

  // Result register and pulses
  vexp_output_stage vexp_output_stage_inst (
    .CLK             (CLK),
    .RST             (RST),
    .eng_done        (eng_done),
    .eng_result      (eng_result),
    .eng_result_last (eng_result_last),
    .DATA_OUT        (DATA_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .READY           (READY)
  );

endmodule

//--- verif/vexp_asserts.sv
`include "vexp_defines.svh"

module vexp_asserts (
  input  logic                CLK,
  input  logic                RST,
  input  logic                START,
  input  logic                DATA_IN_ENABLE,
  input  logic                DATA_OUT_ENABLE,
  input  logic                READY,
  input  logic                eng_start,
  input  logic                eng_done,
  input  logic                slot_full,
  input  vexp_pkg::seq_state_t seq_state
);

  timeunit 1ns;
  timeprecision 100ps;

  import vexp_pkg::*;

  ////////////////////////////////////////////////////////////
  // Output pulses
  ////////////////////////////////////////////////////////////

  // READY only rides on the final result
  ready_with_data: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE)
    else $error("READY high without DATA_OUT_ENABLE");

  ////////////////////////////////////////////////////////////
  // Source spacing and engine timing
  ////////////////////////////////////////////////////////////

  // Slot may refill only in the handoff cycle
  no_strobe_into_full_slot: assert property (@(posedge CLK) disable iff (RST)
    (DATA_IN_ENABLE && seq_state == SEQ_RUN) |-> (!slot_full || eng_start))
    else $error("Element strobe arrived while the holding slot was full");

  // Fixed engine latency
  engine_latency: assert property (@(posedge CLK) disable iff (RST)
    eng_start |-> ##(`VEXP_ENGINE_LAT) eng_done)
    else $error("eng_done did not follow eng_start after the engine latency");

  // New vector only from idle
  start_when_idle: assert property (@(posedge CLK) disable iff (RST)
    START |-> (seq_state == SEQ_IDLE))
    else $error("START arrived while a vector was active");

endmodule

// Attach to every top level instance
bind vexp_top vexp_asserts vexp_asserts_inst (
  .CLK             (CLK),
  .RST             (RST),
  .START           (START),
  .DATA_IN_ENABLE  (DATA_IN_ENABLE),
  .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
  .READY           (READY),
  .eng_start       (eng_start),
  .eng_done        (eng_done),
  .slot_full       (vexp_input_sequencer_inst.slot_full),
  .seq_state       (vexp_input_sequencer_inst.state_q)
);

//--- verif/vexp_tb.sv
`include "vexp_defines.svh"

module vexp_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import vexp_pkg::*;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  localparam int    CLK_HALF    = 4;
  localparam int    RST_CYCLES  = 8;
  localparam int    SEED        = 32'hd8e3;
  localparam int    MARGIN      = 200;
  localparam int    MAX_EXTRA   = 3;
  localparam int    MIN_GAP     = `VEXP_ENGINE_LAT + 1;
  localparam string DATA_FILE   = "verif/vexp_tests.dat";

  ////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////

  logic CLK;
  logic RST;
  logic START;
  len_t SIZE_IN;
  logic DATA_IN_ENABLE;
  fix_t DATA_IN;
  fix_t DATA_OUT;
  logic DATA_OUT_ENABLE;
  logic READY;

  ////////////////////////////////////////////////////////////
  // Test data and bookkeeping
  ////////////////////////////////////////////////////////////

  // Per vector length and gap
  int   vec_len[$];
  int   vec_gap[$];
  // All elements of all vectors in file order
  fix_t elem_in[$];
  fix_t elem_exp[$];

  // Results still owed by the DUT
  fix_t exp_queue[$];

  int   errors;
  int   tests_done;
  int   cur_len;
  int   out_count;
  int   vec_errors_base;
  bit   vector_done;
  int   cycles;
  int   cycle_limit;
  bit   limit_valid;

  vexp_top vexp_top_inst (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .SIZE_IN         (SIZE_IN),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_IN         (DATA_IN),
    .DATA_OUT        (DATA_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .READY           (READY)
  );

  // 8 ns clock
  always #(CLK_HALF) CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Parse the data file into the vector and element queues
  task automatic load_tests();
    int    fd;
    int    n;
    int    a;
    int    b;
    string line;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the test data file %s", DATA_FILE);
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line[0] == "v") begin
        if ($sscanf(line, "v %d %d", a, b) == 2) begin
          vec_len.push_back(a);
          vec_gap.push_back(b);
        end
      end else if (n > 1 && line[0] == "e") begin
        if ($sscanf(line, "e %h %h", a, b) == 2) begin
          elem_in.push_back(fix_t'(a));
          elem_exp.push_back(fix_t'(b));
        end
      end
    end
    $fclose(fd);
  endtask

  // One strobe, held for a single cycle
  task automatic drive_element(input fix_t x, input fix_t expected);
    @(negedge CLK);
    DATA_IN_ENABLE = 1'b1;
    DATA_IN        = x;
    exp_queue.push_back(expected);
    @(negedge CLK);
    DATA_IN_ENABLE = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge CLK);
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////

  // Outputs settle after the rising edge, sample at the falling one
  always @(negedge CLK) begin
    if (!RST && DATA_OUT_ENABLE) begin
      if (exp_queue.size() == 0) begin
        $display("DATA_OUT_ENABLE pulsed at %0t ns with no result outstanding", $time);
        errors++;
      end else begin
        check_value("DATA_OUT", exp_queue.pop_front(), DATA_OUT);
        check_value("READY", (out_count == cur_len - 1), READY);
        out_count++;
        if (out_count == cur_len) begin
          vector_done = 1'b1;
          out_count   = 0;
        end
      end
    end else if (!RST && READY) begin
      $display("READY pulsed at %0t ns without DATA_OUT_ENABLE", $time);
      errors++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Timeout
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    cycles++;
    if (limit_valid && cycles >= cycle_limit) begin
      $display("Run did not finish within %0d cycles, the DUT stopped responding",
               cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int elem_pos;
    int spacing;
    int extra;
    CLK             = 1'b0;
    RST             = 1'b1;
    START           = 1'b0;
    SIZE_IN         = '0;
    DATA_IN_ENABLE  = 1'b0;
    DATA_IN         = '0;
    errors          = 0;
    tests_done      = 0;
    cur_len         = 0;
    out_count       = 0;
    vector_done     = 1'b0;
    cycles          = 0;
    cycle_limit     = 0;
    limit_valid     = 1'b0;
    elem_pos        = 0;
    void'($urandom(SEED));

    load_tests();

    // Worst case run length from the file contents
    cycle_limit = RST_CYCLES + MARGIN;
    for (int v = 0; v < vec_len.size(); v++) begin
      cycle_limit += vec_len[v] * (`VEXP_ENGINE_LAT + 2 + vec_gap[v] + MAX_EXTRA);
    end
    limit_valid = 1'b1;

    // Reset, outputs must stay quiet
    repeat (RST_CYCLES) begin
      @(negedge CLK);
      check_value("DATA_OUT_ENABLE", 1'b0, DATA_OUT_ENABLE);
      check_value("READY", 1'b0, READY);
    end
    RST = 1'b0;
    wait_cycles(2);
    check_value("DATA_OUT_ENABLE", 1'b0, DATA_OUT_ENABLE);
    check_value("READY", 1'b0, READY);

    for (int v = 0; v < vec_len.size(); v++) begin
      vec_errors_base = errors;
      cur_len         = vec_len[v];
      vector_done     = 1'b0;
      // Vector start, right after the previous READY
      @(negedge CLK);
      START   = 1'b1;
      SIZE_IN = len_t'(vec_len[v]);
      @(negedge CLK);
      START   = 1'b0;
      for (int i = 0; i < vec_len[v]; i++) begin
        if (i > 0) begin
          // Jitter only on vectors above the minimum spacing
          extra   = (vec_gap[v] > MIN_GAP) ? $urandom_range(0, MAX_EXTRA) : 0;
          spacing = vec_gap[v] + extra;
          wait_cycles(spacing - 2);
        end
        drive_element(elem_in[elem_pos], elem_exp[elem_pos]);
        elem_pos++;
      end
      while (!vector_done) begin
        @(negedge CLK);
      end
      tests_done++;
      $display("Test %0d: length %0d gap %0d, %0d errors", v, vec_len[v], vec_gap[v],
               errors - vec_errors_base);
    end

    // No stray pulses once all vectors are done
    wait_cycles(`VEXP_ENGINE_LAT + 4);

    $display("Tests %0d, errors %0d", tests_done, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verif/vexp_tests.dat
// v <length> <gap cycles between strobes>, decimal
// e <input hex> <expected exp(input) hex>, Q16.16
// Single zero, result 1.0
v 1 40
e 00000000 00010000
// +-1 and +-2 with wide gaps
v 4 60
e 00010000 0002b7dc
e ffff0000 00005e2a
e 00020000 00076390
e fffe0000 000022a3
// Same values at minimum spacing
v 4 24
e 00010000 0002b7dc
e ffff0000 00005e2a
e 00020000 00076390
e fffe0000 000022a3
// Halves and zero, tight
v 3 24
e 00008000 0001a610
e ffff8000 00009b43
e 00000000 00010000
// Length one back to back
v 1 24
e 00020000 00076390
v 1 24
e fffe0000 000022a3
// Halves again with a medium gap
v 2 30
e ffff8000 00009b43
e 00008000 0001a610
// Mixed longer vector
v 6 26
e 00000000 00010000
e 00010000 0002b7dc
e fffe0000 000022a3
e 00008000 0001a610
e ffff0000 00005e2a
e 00020000 00076390

//--- vlog.f
+incdir+include
src/vexp_pkg.sv
src/vexp_input_sequencer.sv
src/vexp_scalar_exponentiator.sv
src/vexp_output_stage.sv
src/vexp_top.sv
verif/vexp_asserts.sv
verif/vexp_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -f vlog.f --top-module vexp_tb -Mdir obj_dir
	./obj_dir/Vvexp_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	else \
	  echo "Simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
